//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_cadr_overlord
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/cadr_defs.svh
// CADR overlord console constants
// Fetch pacing, boot PROM limit and console register map
`ifndef CADR_DEFS_SVH
`define CADR_DEFS_SVH

// Clock cycles per micro fetch
`define CADR_FETCH_CYCLES 4

// Micro PC where the boot PROM region ends
`define CADR_PROM_END 16

`define CADR_SCRATCH_RESET 16'h1234

// Console register byte offsets
`define CADR_REG_MODE    5'h00
`define CADR_REG_SCRATCH 5'h04
`define CADR_REG_OPC     5'h08
`define CADR_REG_CLK     5'h0C
`define CADR_REG_STATUS  5'h10
`define CADR_REG_UPC     5'h14

`endif

//--- rtl/cadr_overlord_top.sv
// CADR overlord console top level
// AXI4-Lite host port, console registers and stand-in sequencer
`timescale 1ns/1ps

module cadr_overlord_top
(
   input  logic                clk,
   input  logic                reset,
   input  cadr_pkg::reg_addr_t awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  cadr_pkg::spy_word_t wdata,
   input  logic                wvalid,
   output logic                wready,
   output cadr_pkg::axi_resp_t bresp,
   output logic                bvalid,
   input  logic                bready,
   input  cadr_pkg::reg_addr_t araddr,
   input  logic                arvalid,
   output logic                arready,
   output cadr_pkg::spy_word_t rdata,
   output cadr_pkg::axi_resp_t rresp,
   output logic                rvalid,
   input  logic                rready,
   input  logic                boot,
   input  logic                statstop,
   input  logic                waiting,
   input  logic                error,
   output logic                machrun,
   output logic                opcinh,
   output logic                opcclk,
   output logic                lpc_hold,
   output logic                idebug
);
   import cadr_pkg::*;

   upc_t upc;
   logic errstop;
   logic errhalt;
   logic state_fetch;
   logic set_promdisable;

   spy_bus_if spy_bus_i ();

   spy_axil_slave spy_axil_slave_i
   (
      .clk     (clk),
      .reset   (reset),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .spy     (spy_bus_i.host),
      .upc     (upc)
   );

   // PROM disable has no consumer without the datapath
   overlord_ctrl overlord_ctrl_i
   (
      .clk             (clk),
      .reset           (reset),
      .spy             (spy_bus_i.console),
      .boot            (boot),
      .statstop        (statstop),
      .waiting         (waiting),
      .errhalt         (errhalt),
      .state_fetch     (state_fetch),
      .set_promdisable (set_promdisable),
      .machrun         (machrun),
      .errstop         (errstop),
      .promdisable     (),
      .opcinh          (opcinh),
      .opcclk          (opcclk),
      .lpc_hold        (lpc_hold),
      .idebug          (idebug)
   );

   micro_cycle_sequencer micro_cycle_sequencer_i
   (
      .clk             (clk),
      .reset           (reset),
      .machrun         (machrun),
      .errstop         (errstop),
      .error           (error),
      .state_fetch     (state_fetch),
      .upc             (upc),
      .set_promdisable (set_promdisable),
      .errhalt         (errhalt)
   );

endmodule

//--- rtl/cadr_pkg.sv
// CADR overlord shared types
// Spy word, micro PC, register offset, AXI response and slave states
package cadr_pkg;

   // Spy bus and AXI data word
   typedef logic [15:0] spy_word_t;

   // Micro PC of the stand-in sequencer
   typedef logic [13:0] upc_t;

   // Byte offset of a console register
   typedef logic [4:0] reg_addr_t;

   // AXI response code
   typedef logic [1:0] axi_resp_t;

   typedef enum logic [1:0]
   {
      axil_idle,
      axil_wresp,
      axil_rdata
   } axil_state_t;

endpackage

//--- rtl/micro_cycle_sequencer.sv
// Stand-in microsequencer for the overlord
// Paces fetches while running, advances the micro PC, latches error halt
`timescale 1ns/1ps
`include "cadr_defs.svh"

module micro_cycle_sequencer
(
   input  logic           clk,
   input  logic           reset,
   input  logic           machrun,
   input  logic           errstop,
   input  logic           error,
   output logic           state_fetch,
   output cadr_pkg::upc_t upc,
   output logic           set_promdisable,
   output logic           errhalt
);
   import cadr_pkg::*;

   localparam int cnt_w = $clog2(`CADR_FETCH_CYCLES);
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`CADR_FETCH_CYCLES - 1);

   logic [cnt_w-1:0] cyc_cnt;
   upc_t             upc_next;
   logic             fetch;

   assign fetch    = machrun && (cyc_cnt == cnt_last);
   assign upc_next = upc + 1'b1;   // wraps at the micro PC width

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cyc_cnt         <= '0;
         upc             <= '0;
         state_fetch     <= 1'b0;
         set_promdisable <= 1'b0;
      end
      else
      begin
         state_fetch     <= fetch;
         set_promdisable <= fetch && (upc_next == upc_t'(`CADR_PROM_END));
         // Count only while the machine runs
         if (!machrun || fetch)
            cyc_cnt <= '0;
         else
            cyc_cnt <= cyc_cnt + 1'b1;
         if (fetch)
            upc <= upc_next;
      end
   end

   // Error halt holds until errstop is dropped
   always_ff @(posedge clk)
   begin
      if (reset)
         errhalt <= 1'b0;
      else if (!errstop)
         errhalt <= 1'b0;
      else if (error)
         errhalt <= 1'b1;
   end

endmodule

//--- rtl/overlord_ctrl.sv
// Overlord console registers and run control
// Mode, scratch, OPC and clock registers, single step and machine run
`timescale 1ns/1ps
`include "cadr_defs.svh"

module overlord_ctrl
(
   input  logic      clk,
   input  logic      reset,
   spy_bus_if.console spy,
   input  logic      boot,
   input  logic      statstop,
   input  logic      waiting,
   input  logic      errhalt,
   input  logic      state_fetch,
   input  logic      set_promdisable,
   output logic      machrun,
   output logic      errstop,
   output logic      promdisable,
   output logic      opcinh,
   output logic      opcclk,
   output logic      lpc_hold,
   output logic      idebug
);
   import cadr_pkg::*;

   spy_word_t scratch;
   logic      trapenb;
   logic      stathenb;
   logic      ldstat;
   logic      nop11;
   logic      step;
   logic      run;
   logic      srun;
   logic      sstep;
   logic      ssdone;
   logic      promdisabled;
   logic      stathalt;

   // Mode register, PROM disable may also be set by the sequencer
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         promdisable <= 1'b0;
         trapenb     <= 1'b0;
         stathenb    <= 1'b0;
         errstop     <= 1'b0;
      end
      else if (spy.ldmode)
      begin
         promdisable <= spy.spy_in[5];
         trapenb     <= spy.spy_in[4];
         stathenb    <= spy.spy_in[3];
         errstop     <= spy.spy_in[2];
      end
      else if (set_promdisable)
         promdisable <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         scratch <= `CADR_SCRATCH_RESET;
      else if (spy.ldscratch)
         scratch <= spy.spy_in;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         opcinh   <= 1'b0;
         opcclk   <= 1'b0;
         lpc_hold <= 1'b0;
      end
      else if (spy.ldopc)
      begin
         opcinh   <= spy.spy_in[2];
         opcclk   <= spy.spy_in[1];
         lpc_hold <= spy.spy_in[0];
      end
   end

   // Clock register, boot forces run on
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ldstat <= 1'b0;
         idebug <= 1'b0;
         nop11  <= 1'b0;
         step   <= 1'b0;
         run    <= 1'b0;
      end
      else
      begin
         if (spy.ldclk)
         begin
            ldstat <= spy.spy_in[4];
            idebug <= spy.spy_in[3];
            nop11  <= spy.spy_in[2];
            step   <= spy.spy_in[1];
         end
         if (boot)
            run <= 1'b1;
         else if (spy.ldclk)
            run <= spy.spy_in[0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         srun         <= 1'b0;
         sstep        <= 1'b0;
         ssdone       <= 1'b0;
         promdisabled <= 1'b0;
      end
      else
      begin
         srun         <= run;
         sstep        <= step;
         promdisabled <= promdisable;
         // A fresh step request starts a new single cycle
         if (step && !sstep)
            ssdone <= 1'b0;
         if (state_fetch)
            ssdone <= sstep;
      end
   end

   assign stathalt = statstop & stathenb;
   assign machrun  = (sstep & ~ssdone) | (srun & ~errhalt & ~waiting & ~stathalt);

   assign spy.scratch = scratch;
   assign spy.mode    = {promdisable, trapenb, stathenb, errstop};
   assign spy.opc     = {opcinh, opcclk, lpc_hold};
   assign spy.clkctl  = {ldstat, idebug, nop11, step, run};
   assign spy.status  = {errhalt, stathalt, promdisabled, ssdone, srun, machrun};

   a_ssdone_on_fetch: assert property (@(posedge clk) disable iff (reset)
      $rose(ssdone) |-> $past(state_fetch));

endmodule

//--- rtl/spy_axil_slave.sv
// AXI4-Lite slave for the overlord console
// Host writes become spy load strobes, reads return console fields
`timescale 1ns/1ps
`include "cadr_defs.svh"

module spy_axil_slave
(
   input  logic                clk,
   input  logic                reset,
   input  cadr_pkg::reg_addr_t awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  cadr_pkg::spy_word_t wdata,
   input  logic                wvalid,
   output logic                wready,
   output cadr_pkg::axi_resp_t bresp,
   output logic                bvalid,
   input  logic                bready,
   input  cadr_pkg::reg_addr_t araddr,
   input  logic                arvalid,
   output logic                arready,
   output cadr_pkg::spy_word_t rdata,
   output cadr_pkg::axi_resp_t rresp,
   output logic                rvalid,
   input  logic                rready,
   spy_bus_if.host             spy,
   input  cadr_pkg::upc_t      upc
);
   import cadr_pkg::*;

   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

   axil_state_t state;
   reg_addr_t   wr_addr;
   reg_addr_t   rd_addr;
   spy_word_t   wr_data;
   spy_word_t   rd_word;
   logic        rd_ok;
   logic        wr_ok;

   // Only the four loadable registers accept writes
   assign wr_ok = wr_addr inside {`CADR_REG_MODE, `CADR_REG_SCRATCH,
                                  `CADR_REG_OPC, `CADR_REG_CLK};

   assign spy.spy_in = wr_data;

   always_comb
   begin
      rd_word = '0;
      rd_ok   = 1'b1;
      case (rd_addr)
         `CADR_REG_MODE:    rd_word = spy_word_t'({spy.mode, 2'b00});
         `CADR_REG_SCRATCH: rd_word = spy.scratch;
         `CADR_REG_OPC:     rd_word = spy_word_t'(spy.opc);
         `CADR_REG_CLK:     rd_word = spy_word_t'(spy.clkctl);
         `CADR_REG_STATUS:  rd_word = spy_word_t'(spy.status);
         `CADR_REG_UPC:     rd_word = spy_word_t'(upc);
         default:           rd_ok   = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= axil_idle;
         awready       <= 1'b0;
         wready        <= 1'b0;
         arready       <= 1'b0;
         bvalid        <= 1'b0;
         rvalid        <= 1'b0;
         spy.ldmode    <= 1'b0;
         spy.ldscratch <= 1'b0;
         spy.ldopc     <= 1'b0;
         spy.ldclk     <= 1'b0;
      end
      else
      begin
         spy.ldmode    <= 1'b0;
         spy.ldscratch <= 1'b0;
         spy.ldopc     <= 1'b0;
         spy.ldclk     <= 1'b0;
         case (state)
            axil_idle:
               // Writes win over reads
               if (awvalid && wvalid)
               begin
                  awready <= 1'b1;
                  wready  <= 1'b1;
                  state   <= axil_wresp;
               end
               else if (arvalid)
               begin
                  arready <= 1'b1;
                  state   <= axil_rdata;
               end
            axil_wresp:
               if (awready)
               begin
                  awready       <= 1'b0;
                  wready        <= 1'b0;
                  bvalid        <= 1'b1;
                  spy.ldmode    <= (wr_addr == `CADR_REG_MODE);
                  spy.ldscratch <= (wr_addr == `CADR_REG_SCRATCH);
                  spy.ldopc     <= (wr_addr == `CADR_REG_OPC);
                  spy.ldclk     <= (wr_addr == `CADR_REG_CLK);
               end
               else if (bvalid && bready)
               begin
                  bvalid <= 1'b0;
                  state  <= axil_idle;
               end
            axil_rdata:
               if (arready)
               begin
                  arready <= 1'b0;
                  rvalid  <= 1'b1;
               end
               else if (rvalid && rready)
               begin
                  rvalid <= 1'b0;
                  state  <= axil_idle;
               end
            default:
               state <= axil_idle;
         endcase
      end
   end

   // Address, data and response capture
   always_ff @(posedge clk)
   begin
      if (state == axil_idle)
      begin
         wr_addr <= awaddr;
         wr_data <= wdata;
         rd_addr <= araddr;
      end
      if (state == axil_wresp && awready)
         bresp <= wr_ok ? resp_okay : resp_slverr;
      if (state == axil_rdata && arready)
      begin
         rdata <= rd_word;
         rresp <= rd_ok ? resp_okay : resp_slverr;
      end
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (reset)
      $onehot0({spy.ldmode, spy.ldscratch, spy.ldopc, spy.ldclk}));

   a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid);

endmodule

//--- rtl/spy_bus_if.sv
// Spy bus between the host slave and the console registers
// Load strobes one way, register readback the other
`timescale 1ns/1ps

interface spy_bus_if;
   import cadr_pkg::*;

   spy_word_t   spy_in;
   logic        ldmode;
   logic        ldscratch;
   logic        ldopc;
   logic        ldclk;

   // Readback fields
   spy_word_t   scratch;
   logic [3:0]  mode;     // promdisable, trapenb, stathenb, errstop
   logic [2:0]  opc;      // opcinh, opcclk, lpc_hold
   logic [4:0]  clkctl;   // ldstat, idebug, nop11, step, run
   logic [5:0]  status;   // errhalt down to machrun

   modport host (output spy_in, ldmode, ldscratch, ldopc, ldclk,
                 input  scratch, mode, opc, clkctl, status);

   modport console (input  spy_in, ldmode, ldscratch, ldopc, ldclk,
                    output scratch, mode, opc, clkctl, status);

endinterface

//--- tests/overlord_checker.sv
// Overlord response checker
// Compares AXI responses, read data and console ports with trace values
`timescale 1ns/1ps

module overlord_checker
(
   input  logic                clk,
   input  logic                awready,
   input  logic                wready,
   input  logic                bvalid,
   input  logic                bready,
   input  cadr_pkg::axi_resp_t bresp,
   input  logic                rvalid,
   input  logic                rready,
   input  cadr_pkg::spy_word_t rdata,
   input  cadr_pkg::axi_resp_t rresp,
   input  logic [4:0]          ports,
   input  logic [7:0]          test_num,
   input  cadr_pkg::spy_word_t exp_data,
   input  cadr_pkg::axi_resp_t exp_resp,
   input  logic [1:0]          data_mode,
   input  logic                port_check,
   input  logic                test_end,
   output int                  tests_passed,
   output int                  tests_failed
);
   import cadr_pkg::*;

   spy_word_t kept;
   int        errors;
   int        checks;

   initial
   begin
      tests_passed = 0;
      tests_failed = 0;
      errors       = 0;
      checks       = 0;
      kept         = '0;
   end

   // Sampled mid cycle away from the edges
   always @(negedge clk)
   begin
      // Address and data ready pulse as a pair
      if (awready || wready)
      begin
         checks = checks + 1;
         if (!(awready && wready))
         begin
            $display("** Error test %0d: {awready,wready} is %h, expected 3",
                     test_num, {awready, wready});
            errors = errors + 1;
         end
      end
      if (bvalid && bready)
      begin
         checks = checks + 1;
         if (bresp !== exp_resp)
         begin
            $display("** Error test %0d: bresp is %h, expected %h", test_num, bresp, exp_resp);
            errors = errors + 1;
         end
      end
      if (rvalid && rready)
      begin
         checks = checks + 1;
         if (rresp !== exp_resp)
         begin
            $display("** Error test %0d: rresp is %h, expected %h", test_num, rresp, exp_resp);
            errors = errors + 1;
         end
         // Mode 1 keeps the value for a later same or changed compare
         case (data_mode)
            2'd0:
               if (rdata !== exp_data)
               begin
                  $display("** Error test %0d: rdata is %h, expected %h",
                           test_num, rdata, exp_data);
                  errors = errors + 1;
               end
            2'd1:
               kept = rdata;
            2'd2:
               if (rdata !== kept)
               begin
                  $display("** Error test %0d: rdata is %h, expected %h",
                           test_num, rdata, kept);
                  errors = errors + 1;
               end
            default:
               if (rdata === kept)
               begin
                  $display("** Error test %0d: rdata is %h, expected a change from %h",
                           test_num, rdata, kept);
                  errors = errors + 1;
               end
         endcase
      end
      if (port_check)
      begin
         checks = checks + 1;
         if (ports !== exp_data[4:0])
         begin
            $display("** Error test %0d: {machrun,opcinh,opcclk,lpc_hold,idebug} is %h, expected %h",
                     test_num, ports, exp_data[4:0]);
            errors = errors + 1;
         end
      end
      if (test_end)
      begin
         if (errors == 0)
         begin
            $display("test %0d passed, %0d checks", test_num, checks);
            tests_passed = tests_passed + 1;
         end
         else
         begin
            $display("test %0d failed, %0d of %0d checks wrong", test_num, errors, checks);
            tests_failed = tests_failed + 1;
         end
         errors = 0;
         checks = 0;
      end
   end

endmodule

//--- tests/overlord_trace.txt
// kind_test_offset_data_resp_side; kind 1 write, 2 read, 3 idle (data = cycles), 4 port check,
// 5 read and keep, 6 read same as kept, 7 read changed; side = boot statstop waiting error
2_01_04_1234_0_0
1_01_04_ABCD_0_0
2_01_04_ABCD_0_0
1_01_00_FF17_0_0
2_01_00_0014_0_0
1_01_08_FFF5_0_0
2_01_08_0005_0_0
1_01_0C_FFF8_0_0
2_01_0C_0018_0_0
4_01_00_000B_0_0
1_01_00_0000_0_0
1_02_10_FFFF_2_0
1_02_14_1234_2_0
1_02_18_5A5A_2_0
2_02_18_0000_2_0
2_02_02_0000_2_0
2_02_04_ABCD_0_0
2_02_14_0000_0_0
2_02_10_0000_0_0
2_02_0C_0018_0_0
1_03_0C_0002_0_0
3_03_00_000C_0_0
2_03_14_0001_0_0
2_03_10_0004_0_0
1_03_0C_0000_0_0
1_03_0C_0002_0_0
3_03_00_000C_0_0
2_03_14_0002_0_0
2_03_10_0004_0_0
4_03_00_000A_0_0
1_03_0C_0000_0_0
3_04_00_0001_0_8
3_04_00_0002_0_0
4_04_00_001A_0_0
3_04_00_0046_0_0
2_04_10_000B_0_0
2_04_00_0020_0_0
1_04_00_0028_0_4
3_04_00_0002_0_4
5_04_14_0000_0_4
3_04_00_000A_0_4
6_04_14_0000_0_4
2_04_10_001A_0_4
1_05_00_0024_0_0
3_05_00_0003_0_0
3_05_00_0001_0_1
3_05_00_0002_0_0
5_05_14_0000_0_0
3_05_00_000A_0_0
6_05_14_0000_0_0
2_05_10_002A_0_0
4_05_00_000A_0_0
1_05_00_0020_0_0
3_05_00_000A_0_0
7_05_14_0000_0_0

//--- tests/tb_cadr_overlord.sv
// Testbench for the CADR overlord console
// Replays a trace of host operations against the DUT
`timescale 1ns/1ps

module tb_cadr_overlord;
   import cadr_pkg::*;

   localparam int trace_depth = 128;

   logic      clk = 1'b0;
   logic      reset;
   reg_addr_t awaddr;
   logic      awvalid;
   logic      awready;
   spy_word_t wdata;
   logic      wvalid;
   logic      wready;
   axi_resp_t bresp;
   logic      bvalid;
   logic      bready;
   reg_addr_t araddr;
   logic      arvalid;
   logic      arready;
   spy_word_t rdata;
   axi_resp_t rresp;
   logic      rvalid;
   logic      rready;
   logic      boot;
   logic      statstop;
   logic      waiting;
   logic      error;
   logic      machrun;
   logic      opcinh;
   logic      opcclk;
   logic      lpc_hold;
   logic      idebug;

   // Trace entries of kind, test, offset, data, response and side inputs
   logic [43:0] trace [trace_depth];
   logic [7:0]  lfsr;
   logic [7:0]  test_num;
   spy_word_t   exp_data;
   axi_resp_t   exp_resp;
   logic [1:0]  data_mode;
   logic        port_check;
   logic        test_end;
   int          tests_passed;
   int          tests_failed;
   int          bad_lines = 0;
   int          trace_len = 0;
   int          cycles = 0;
   int          limit = 0;

   cadr_overlord_top cadr_overlord_top_i
   (
      .clk      (clk),
      .reset    (reset),
      .awaddr   (awaddr),
      .awvalid  (awvalid),
      .awready  (awready),
      .wdata    (wdata),
      .wvalid   (wvalid),
      .wready   (wready),
      .bresp    (bresp),
      .bvalid   (bvalid),
      .bready   (bready),
      .araddr   (araddr),
      .arvalid  (arvalid),
      .arready  (arready),
      .rdata    (rdata),
      .rresp    (rresp),
      .rvalid   (rvalid),
      .rready   (rready),
      .boot     (boot),
      .statstop (statstop),
      .waiting  (waiting),
      .error    (error),
      .machrun  (machrun),
      .opcinh   (opcinh),
      .opcclk   (opcclk),
      .lpc_hold (lpc_hold),
      .idebug   (idebug)
   );

   overlord_checker overlord_checker_i
   (
      .clk          (clk),
      .awready      (awready),
      .wready       (wready),
      .bvalid       (bvalid),
      .bready       (bready),
      .bresp        (bresp),
      .rvalid       (rvalid),
      .rready       (rready),
      .rdata        (rdata),
      .rresp        (rresp),
      .ports        ({machrun, opcinh, opcclk, lpc_hold, idebug}),
      .test_num     (test_num),
      .exp_data     (exp_data),
      .exp_resp     (exp_resp),
      .data_mode    (data_mode),
      .port_check   (port_check),
      .test_end     (test_end),
      .tests_passed (tests_passed),
      .tests_failed (tests_failed)
   );

   always #50 clk = ~clk;

   // Galois form of x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_next(input logic [7:0] state);
      if (state[0])
         return (state >> 1) ^ 8'hB8;
      else
         return state >> 1;
   endfunction

   task automatic take_bit(output logic value);
      value = lfsr[0];
      lfsr  = lfsr_next(lfsr);
   endtask

   task automatic wait_cycles(input int count);
      repeat (count)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input spy_word_t data);
      logic done;
      logic ready;
      done    = 1'b0;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      wait_cycles(1);
      while (!awready)
         wait_cycles(1);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      // Random stalls on bready
      while (!done)
      begin
         if (bvalid)
         begin
            take_bit(ready);
            bready = ready;
            done   = ready;
         end
         wait_cycles(1);
      end
      bready = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr);
      logic done;
      logic ready;
      done    = 1'b0;
      araddr  = addr;
      arvalid = 1'b1;
      wait_cycles(1);
      while (!arready)
         wait_cycles(1);
      arvalid = 1'b0;
      while (!done)
      begin
         if (rvalid)
         begin
            take_bit(ready);
            rready = ready;
            done   = ready;
         end
         wait_cycles(1);
      end
      rready = 1'b0;
   endtask

   task automatic request_port_check();
      port_check = 1'b1;
      wait_cycles(1);
      port_check = 1'b0;
   endtask

   task automatic close_test();
      test_end = 1'b1;
      wait_cycles(1);
      test_end = 1'b0;
   endtask

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit)
      begin
         $display("Timeout after %0d cycles, the trace did not finish", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial
   begin
      logic [43:0] entry;
      int          idx;
      for (idx = 0; idx < trace_depth; idx++)
         trace[idx] = {4'hF, 40'(idx)};
      $readmemh("tests/overlord_trace.txt", trace);
      while (trace_len < trace_depth && trace[trace_len][43:40] != 4'hF)
         trace_len++;
      limit = trace_len * 20 + 200;

      lfsr       = 8'd27;
      reset      = 1'b1;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      boot       = 1'b0;
      statstop   = 1'b0;
      waiting    = 1'b0;
      error      = 1'b0;
      test_num   = '0;
      exp_data   = '0;
      exp_resp   = '0;
      data_mode  = '0;
      port_check = 1'b0;
      test_end   = 1'b0;
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;

      for (idx = 0; idx < trace_len; idx++)
      begin
         entry = trace[idx];
         if (test_num != 0 && entry[39:32] != test_num)
            close_test();
         test_num = entry[39:32];
         exp_data = entry[23:8];
         exp_resp = entry[5:4];
         {boot, statstop, waiting, error} = entry[3:0];
         case (entry[43:40])
            4'h1:
               write_reg(entry[28:24], entry[23:8]);
            4'h2:
            begin
               data_mode = 2'd0;
               read_reg(entry[28:24]);
            end
            4'h3:
               wait_cycles(int'(entry[23:8]));
            4'h4:
               request_port_check();
            4'h5, 4'h6, 4'h7:
            begin
               data_mode = 2'(entry[43:40] - 4'h4);
               read_reg(entry[28:24]);
            end
            default:
            begin
               $display("Trace line %0d has an unknown operation kind", idx);
               bad_lines++;
            end
         endcase
      end
      if (test_num != 0)
         close_test();

      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && bad_lines == 0 && tests_passed > 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+rtl
rtl/cadr_pkg.sv
rtl/spy_bus_if.sv
rtl/spy_axil_slave.sv
rtl/overlord_ctrl.sv
rtl/micro_cycle_sequencer.sv
rtl/cadr_overlord_top.sv
tests/overlord_checker.sv
tests/tb_cadr_overlord.sv
